// File: src/cmx_settings.svh
// Counter unit sizes, burst and record layout, node field and opcode codes
`ifndef CMX_SETTINGS_SVH
`define CMX_SETTINGS_SVH

// Counter memory geometry
`define CMX_ADR_W 10
`define CMX_WORD_W 16

// Log2 of words per counter record
`define CMX_REC_W 3

// Burst length field, value plus one words
`define CMX_LEN_W 3

// Destination word layout
`define CMX_NODE_W 12
`define CMX_DEST_VALID_BIT 12

// Host opcodes
`define CMX_OP_W 4
`define CMX_OP_CNT_WRITE 0
`define CMX_OP_CNT_READ 1
`define CMX_OP_CNT_INCR 2

`endif

// File: src/cmxPkg.sv
// Counter unit vector types, FSM state enums and port structs
`default_nettype none

`include "cmx_settings.svh"

package cmxPkg;

  typedef logic [`CMX_WORD_W-1:0] word_t;
  typedef logic [`CMX_ADR_W-1:0] cntAdr_t;
  typedef logic [`CMX_ADR_W-`CMX_REC_W-1:0] counterId_t;
  typedef logic [`CMX_LEN_W-1:0] rdLen_t;

  typedef enum logic [`CMX_OP_W-1:0] {
    OpCntWrite = `CMX_OP_CNT_WRITE,
    OpCntRead = `CMX_OP_CNT_READ,
    OpCntIncr = `CMX_OP_CNT_INCR
  } opcode_t;

  typedef enum logic [2:0] {
    CtlIdle, CntRead, CntIncr0, CntIncr1, CntIncr2, CntIncr3
  } ctlState_t;

  typedef enum logic [3:0] {
    MniIdle, MniRead0, MniSend00, MniSend01, MniSend02, MniSend03,
    MniRead1, MniSend10, MniSend11, MniSend12, MniSend13
  } mniState_t;

  //////////////////////////////
  // Port bundles
  typedef struct packed {
    logic valid;
    opcode_t opcode;
    rdLen_t rdLen;
    cntAdr_t adr;
    word_t wdata;
  } ctlReq_t;

  typedef struct packed {
    logic valid;
    word_t rdata;
  } ctlResp_t;

  typedef struct packed {
    logic start;
    counterId_t counterId;
    logic error;
  } notifyReq_t;

  typedef struct packed {
    logic valid;
    word_t data;
  } mniWord_t;

endpackage

`default_nettype wire

// File: src/cntMem.sv
// Dual-port counter memory, read/write port 0 and read-only port 1
`timescale 1ns/100ps
`default_nettype none

`include "cmx_settings.svh"

module cntMem (
  input wire logic clk_ni,
  // Port 0, host side
  input cmxPkg::cntAdr_t i_adr0,
  input wire logic i_wen0,
  input cmxPkg::word_t i_wdata0,
  output cmxPkg::word_t o_rdata0,
  // Port 1, notifier side
  input cmxPkg::cntAdr_t i_adr1,
  output cmxPkg::word_t o_rdata1
);

  localparam int Depth = 1 << `CMX_ADR_W;

  cmxPkg::word_t mem [Depth];

  // Old data on a same-cycle write
  always_ff @(posedge clk_ni) begin
    if (i_wen0) begin
      mem[i_adr0] <= i_wdata0;
    end
    o_rdata0 <= mem[i_adr0];
  end

  always_ff @(posedge clk_ni) begin
    o_rdata1 <= mem[i_adr1];
  end

endmodule

`default_nettype wire

// File: src/cntIncrUnit.sv
// Counter increment datapath with amount register, carry and zero detect
`timescale 1ns/100ps
`default_nettype none

`include "cmx_settings.svh"

module cntIncrUnit (
  input wire logic clk_ni,
  input wire logic rst_ni,
  input cmxPkg::ctlState_t i_phase,
  input cmxPkg::word_t i_amount,
  input cmxPkg::word_t i_rdata0,
  output cmxPkg::word_t o_sumLow,
  output cmxPkg::word_t o_sumHigh,
  output logic o_event,
  output logic o_amountZero
);

  cmxPkg::word_t amountReg;
  logic [`CMX_WORD_W:0] sumLowFull;
  logic carry;
  logic lowZero;

  // Amount follows the request while idle, frozen from CntIncr0 on
  always_ff @(posedge clk_ni) begin
    if (i_phase == cmxPkg::CtlIdle) begin
      amountReg <= i_amount;
    end
  end

  assign sumLowFull = {1'b0, i_rdata0} + {1'b0, amountReg};
  assign o_sumLow = sumLowFull[`CMX_WORD_W-1:0];

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      carry <= 1'b0;
      lowZero <= 1'b0;
    end else if (i_phase == cmxPkg::CntIncr1) begin
      carry <= sumLowFull[`CMX_WORD_W];
      lowZero <= (o_sumLow == '0);
    end
  end

  assign o_sumHigh = i_rdata0 + cmxPkg::word_t'(carry);
  assign o_amountZero = (amountReg == '0);

  // Zero crossing or zero amount
  assign o_event = (i_phase == cmxPkg::CntIncr3) &&
                   ((lowZero && (o_sumHigh == '0)) || o_amountZero);

  incrEventA: assert property (@(posedge clk_ni) disable iff (rst_ni)
    o_event |-> ($past(i_phase, 3) == cmxPkg::CntIncr0))
    else $error("counter event outside the increment sequence");

endmodule

`default_nettype wire

// File: src/ctlFsm.sv
// Host command FSM with stall, port 0 control, responses and notify request
`timescale 1ns/100ps
`default_nettype none

`include "cmx_settings.svh"

module ctlFsm (
  input wire logic clk_ni,
  input wire logic rst_ni,
  input cmxPkg::ctlReq_t i_ctlReq,
  input cmxPkg::word_t i_rdata0,
  input wire logic i_notifyBusy,
  input cmxPkg::word_t i_sumLow,
  input cmxPkg::word_t i_sumHigh,
  input wire logic i_event,
  input wire logic i_amountZero,
  output logic o_ctlStall,
  output cmxPkg::ctlResp_t o_ctlResp,
  output cmxPkg::cntAdr_t o_adr0,
  output logic o_wen0,
  output cmxPkg::word_t o_wdata0,
  output cmxPkg::ctlState_t o_incrPhase,
  output logic o_intCnt,
  output cmxPkg::counterId_t o_intCntId,
  output cmxPkg::notifyReq_t o_notifyReq
);

  cmxPkg::ctlState_t state;
  cmxPkg::ctlState_t nextState;
  cmxPkg::cntAdr_t adrReg;
  cmxPkg::rdLen_t readCnt;
  cmxPkg::rdLen_t rdOffset;
  cmxPkg::counterId_t counterId;
  logic respValid;
  logic isWrite;
  logic isRead;
  logic isIncr;
  logic accept;

  assign isWrite = (i_ctlReq.opcode == cmxPkg::OpCntWrite);
  assign isRead = (i_ctlReq.opcode == cmxPkg::OpCntRead);
  assign isIncr = (i_ctlReq.opcode == cmxPkg::OpCntIncr);

  // Increments wait for the notifier to drain
  assign o_ctlStall = (state != cmxPkg::CtlIdle) ||
                      (i_ctlReq.valid && isIncr && i_notifyBusy);
  assign accept = i_ctlReq.valid && !o_ctlStall;

  //////////////////////////////
  // State machine
  always_comb begin
    nextState = state;
    case (state)
      cmxPkg::CtlIdle: begin
        if (accept && isRead) begin
          nextState = cmxPkg::CntRead;
        end else if (accept && isIncr) begin
          nextState = cmxPkg::CntIncr0;
        end
      end
      cmxPkg::CntRead: if (readCnt == '0) nextState = cmxPkg::CtlIdle;
      cmxPkg::CntIncr0: nextState = cmxPkg::CntIncr1;
      cmxPkg::CntIncr1: nextState = cmxPkg::CntIncr2;
      cmxPkg::CntIncr2: nextState = cmxPkg::CntIncr3;
      default: nextState = cmxPkg::CtlIdle;
    endcase
  end

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      state <= cmxPkg::CtlIdle;
      readCnt <= '0;
      respValid <= 1'b0;
    end else begin
      state <= nextState;
      respValid <= (state == cmxPkg::CntRead);
      if (state == cmxPkg::CtlIdle) begin
        readCnt <= i_ctlReq.rdLen;
      end else if (state == cmxPkg::CntRead) begin
        readCnt <= readCnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_ni) begin
    if (state == cmxPkg::CtlIdle) begin
      adrReg <= i_ctlReq.adr;
      rdOffset <= '0;
    end else if (state == cmxPkg::CntRead) begin
      rdOffset <= rdOffset + 1'b1;
    end
  end

  assign counterId = adrReg[`CMX_ADR_W-1:`CMX_REC_W];

  //////////////////////////////
  // Port 0 select
  always_comb begin
    o_adr0 = i_ctlReq.adr;
    o_wen0 = 1'b0;
    o_wdata0 = i_ctlReq.wdata;
    case (state)
      cmxPkg::CtlIdle: o_wen0 = accept && isWrite;
      // Burst address wraps at the top of memory
      cmxPkg::CntRead: o_adr0 = adrReg + cmxPkg::cntAdr_t'(rdOffset);
      cmxPkg::CntIncr0: o_adr0 = {counterId, `CMX_REC_W'(0)};
      cmxPkg::CntIncr1: begin
        o_adr0 = {counterId, `CMX_REC_W'(0)};
        o_wen0 = 1'b1;
        o_wdata0 = i_sumLow;
      end
      cmxPkg::CntIncr2: o_adr0 = {counterId, `CMX_REC_W'(1)};
      cmxPkg::CntIncr3: begin
        o_adr0 = {counterId, `CMX_REC_W'(1)};
        o_wen0 = 1'b1;
        o_wdata0 = i_sumHigh;
      end
      default: o_wen0 = 1'b0;
    endcase
  end

  assign o_ctlResp = '{valid: respValid, rdata: i_rdata0};
  assign o_incrPhase = state;

  // Interrupt and notify start share the CntIncr3 pulse
  assign o_intCnt = i_event;
  assign o_intCntId = counterId;
  assign o_notifyReq = '{start: i_event, counterId: counterId, error: i_amountZero};

  noWriteInReadA: assert property (@(posedge clk_ni) disable iff (rst_ni)
    (state == cmxPkg::CntRead) |-> !o_wen0)
    else $error("port 0 write during a burst read");

  stateRangeA: assert property (@(posedge clk_ni) disable iff (rst_ni)
    !$isunknown(state) && (state inside {cmxPkg::CtlIdle, cmxPkg::CntRead,
      cmxPkg::CntIncr0, cmxPkg::CntIncr1, cmxPkg::CntIncr2, cmxPkg::CntIncr3}))
    else $error("control state out of range");

endmodule

`default_nettype wire

// File: src/mniNotifier.sv
// Notification FSM reading the counter record on port 1 and sending words
`timescale 1ns/100ps
`default_nettype none

`include "cmx_settings.svh"

module mniNotifier (
  input wire logic clk_ni,
  input wire logic rst_ni,
  input cmxPkg::notifyReq_t i_notifyReq,
  input cmxPkg::word_t i_rdata1,
  input wire logic i_mniStall,
  output cmxPkg::cntAdr_t o_adr1,
  output cmxPkg::mniWord_t o_mniWord,
  output logic o_busy
);

  cmxPkg::mniState_t state;
  cmxPkg::mniState_t nextState;
  cmxPkg::counterId_t idReg;
  cmxPkg::counterId_t idSel;
  logic errReg;
  logic destValid;
  logic [`CMX_REC_W-1:0] offset;
  logic sending;
  cmxPkg::word_t data;

  assign destValid = i_rdata1[`CMX_DEST_VALID_BIT];

  always_comb begin
    nextState = state;
    case (state)
      cmxPkg::MniIdle: if (i_notifyReq.start) nextState = cmxPkg::MniRead0;
      cmxPkg::MniRead0: nextState = destValid ? cmxPkg::MniSend00 : cmxPkg::MniRead1;
      cmxPkg::MniSend00: if (!i_mniStall) nextState = cmxPkg::MniSend01;
      cmxPkg::MniSend01: if (!i_mniStall) nextState = cmxPkg::MniSend02;
      cmxPkg::MniSend02: if (!i_mniStall) nextState = cmxPkg::MniSend03;
      cmxPkg::MniSend03: if (!i_mniStall) nextState = cmxPkg::MniRead1;
      cmxPkg::MniRead1: nextState = destValid ? cmxPkg::MniSend10 : cmxPkg::MniIdle;
      cmxPkg::MniSend10: if (!i_mniStall) nextState = cmxPkg::MniSend11;
      cmxPkg::MniSend11: if (!i_mniStall) nextState = cmxPkg::MniSend12;
      cmxPkg::MniSend12: if (!i_mniStall) nextState = cmxPkg::MniSend13;
      cmxPkg::MniSend13: if (!i_mniStall) nextState = cmxPkg::MniIdle;
      default: nextState = cmxPkg::MniIdle;
    endcase
  end

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      state <= cmxPkg::MniIdle;
    end else begin
      state <= nextState;
    end
  end

  always_ff @(posedge clk_ni) begin
    if ((state == cmxPkg::MniIdle) && i_notifyReq.start) begin
      idReg <= i_notifyReq.counterId;
      errReg <= i_notifyReq.error;
    end
  end

  //////////////////////////////
  // Port 1 address, one cycle ahead
  assign idSel = (state == cmxPkg::MniIdle) ? i_notifyReq.counterId : idReg;

  always_comb begin
    case (nextState)
      cmxPkg::MniSend01: offset = `CMX_REC_W'(3);
      cmxPkg::MniSend02: offset = `CMX_REC_W'(2);
      cmxPkg::MniRead1, cmxPkg::MniSend10: offset = `CMX_REC_W'(7);
      cmxPkg::MniSend11: offset = `CMX_REC_W'(5);
      cmxPkg::MniSend12: offset = `CMX_REC_W'(4);
      // Destination 0 word
      default: offset = `CMX_REC_W'(6);
    endcase
  end

  assign o_adr1 = {idSel, offset};

  //////////////////////////////
  // Word formatting
  assign sending = state inside {cmxPkg::MniSend00, cmxPkg::MniSend01, cmxPkg::MniSend02,
    cmxPkg::MniSend03, cmxPkg::MniSend10, cmxPkg::MniSend11, cmxPkg::MniSend12,
    cmxPkg::MniSend13};

  always_comb begin
    case (state)
      cmxPkg::MniSend00, cmxPkg::MniSend10: data = cmxPkg::word_t'(i_rdata1[`CMX_NODE_W-1:0]);
      // Status is 1 for a zero crossing
      cmxPkg::MniSend03, cmxPkg::MniSend13: data = cmxPkg::word_t'(!errReg);
      default: data = i_rdata1;
    endcase
  end

  assign o_mniWord = '{valid: sending, data: data};
  assign o_busy = (state != cmxPkg::MniIdle);

  stallHoldA: assert property (@(posedge clk_ni) disable iff (rst_ni)
    o_mniWord.valid && i_mniStall |=> o_mniWord.valid && $stable(o_mniWord.data))
    else $error("notification word changed under stall");

endmodule

`default_nettype wire

// File: src/cmxTop.sv
// Counter unit top with control FSM, increment unit, memory and notifier
`timescale 1ns/100ps
`default_nettype none

module cmxTop (
  input wire logic clk_ni,
  input wire logic rst_ni,
  input cmxPkg::ctlReq_t i_ctlReq,
  input wire logic i_mniStall,
  output logic o_ctlStall,
  output cmxPkg::ctlResp_t o_ctlResp,
  output logic o_intCnt,
  output cmxPkg::counterId_t o_intCntId,
  output cmxPkg::mniWord_t o_mniWord
);

  cmxPkg::cntAdr_t adr0;
  cmxPkg::cntAdr_t adr1;
  cmxPkg::word_t wdata0;
  cmxPkg::word_t rdata0;
  cmxPkg::word_t rdata1;
  cmxPkg::word_t sumLow;
  cmxPkg::word_t sumHigh;
  cmxPkg::ctlState_t incrPhase;
  cmxPkg::notifyReq_t notifyReq;
  logic wen0;
  logic incrEvent;
  logic amountZero;
  logic notifyBusy;

  ctlFsm ctlFsm0 (
    .clk_ni(clk_ni), .rst_ni(rst_ni), .i_ctlReq(i_ctlReq), .i_rdata0(rdata0),
    .i_notifyBusy(notifyBusy), .i_sumLow(sumLow), .i_sumHigh(sumHigh),
    .i_event(incrEvent), .i_amountZero(amountZero), .o_ctlStall(o_ctlStall),
    .o_ctlResp(o_ctlResp), .o_adr0(adr0), .o_wen0(wen0), .o_wdata0(wdata0),
    .o_incrPhase(incrPhase), .o_intCnt(o_intCnt), .o_intCntId(o_intCntId),
    .o_notifyReq(notifyReq)
  );

  cntIncrUnit cntIncrUnit0 (
    .clk_ni(clk_ni), .rst_ni(rst_ni), .i_phase(incrPhase), .i_amount(i_ctlReq.wdata),
    .i_rdata0(rdata0), .o_sumLow(sumLow), .o_sumHigh(sumHigh), .o_event(incrEvent),
    .o_amountZero(amountZero)
  );

  cntMem cntMem0 (
    .clk_ni(clk_ni), .i_adr0(adr0), .i_wen0(wen0), .i_wdata0(wdata0),
    .o_rdata0(rdata0), .i_adr1(adr1), .o_rdata1(rdata1)
  );

  mniNotifier mniNotifier0 (
    .clk_ni(clk_ni), .rst_ni(rst_ni), .i_notifyReq(notifyReq), .i_rdata1(rdata1),
    .i_mniStall(i_mniStall), .o_adr1(adr1), .o_mniWord(o_mniWord), .o_busy(notifyBusy)
  );

endmodule

`default_nettype wire

// File: tests/cmxTb.sv
// Counter unit testbench with clock, reset, directed tests, checks and summary
`timescale 1ns/100ps
`default_nettype none

module cmxTb;

  logic clk_ni;
  logic rst_ni;
  cmxPkg::ctlReq_t ctlReq;
  logic mniStall;
  logic ctlStall;
  cmxPkg::ctlResp_t ctlResp;
  logic intCnt;
  cmxPkg::counterId_t intCntId;
  cmxPkg::mniWord_t mniWord;

  cmxPkg::word_t model [1024];
  cmxPkg::word_t noteQ [$];
  int cycleCnt = 0;
  int lastNoteCycle;
  int errCnt = 0;
  int timeoutCnt = 0;
  logic randStall;
  int unsigned seedVal;

  cmxTop dut0 (
    .clk_ni(clk_ni), .rst_ni(rst_ni), .i_ctlReq(ctlReq), .i_mniStall(mniStall),
    .o_ctlStall(ctlStall), .o_ctlResp(ctlResp), .o_intCnt(intCnt),
    .o_intCntId(intCntId), .o_mniWord(mniWord)
  );

  initial begin
    clk_ni = 1'b0;
    forever #50 clk_ni = ~clk_ni;
  end

  always @(posedge clk_ni) begin
    cycleCnt <= cycleCnt + 1;
  end

  //////////////////////////////
  // Checks
  task automatic checkWord(input string sig, input cmxPkg::word_t got, input cmxPkg::word_t exp);
    if (got !== exp) begin
      errCnt++;
      $display("ERROR %s: got 0x%h expected 0x%h", sig, got, exp);
    end
  endtask

  task automatic checkFlag(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      errCnt++;
      $display("ERROR %s: got 0x%h expected 0x%h", sig, got, exp);
    end
  endtask

  task automatic checkId(input string sig, input cmxPkg::counterId_t got,
      input cmxPkg::counterId_t exp);
    if (got !== exp) begin
      errCnt++;
      $display("ERROR %s: got 0x%h expected 0x%h", sig, got, exp);
    end
  endtask

  //////////////////////////////
  // Host side
  task automatic sendReq(input cmxPkg::opcode_t op, input cmxPkg::rdLen_t len,
      input cmxPkg::cntAdr_t adr, input cmxPkg::word_t wdata, output int accCycle);
    int waitCnt;
    @(posedge clk_ni);
    ctlReq.valid <= 1'b1;
    ctlReq.opcode <= op;
    ctlReq.rdLen <= len;
    ctlReq.adr <= adr;
    ctlReq.wdata <= wdata;
    waitCnt = 0;
    accCycle = -1;
    while (accCycle < 0 && waitCnt < 200) begin
      @(negedge clk_ni);
      if (!ctlStall) begin
        accCycle = cycleCnt;
      end else begin
        waitCnt++;
      end
    end
    if (accCycle < 0) begin
      timeoutCnt++;
      $display("Timeout: host request was never accepted");
    end
    @(posedge clk_ni);
    ctlReq.valid <= 1'b0;
  endtask

  task automatic writeWord(input cmxPkg::cntAdr_t adr, input cmxPkg::word_t data);
    int accCycle;
    sendReq(cmxPkg::OpCntWrite, 3'd0, adr, data, accCycle);
    model[adr] = data;
  endtask

  // Words 7 down to 0 of one record, word 0 in the low bits
  task automatic setRecord(input cmxPkg::counterId_t id, input logic [127:0] rec);
    for (int i = 0; i < 8; i++) begin
      writeWord({id, 3'(i)}, rec[16*i +: 16]);
    end
  endtask

  task automatic readBurst(input cmxPkg::cntAdr_t adr, input int len);
    int accCycle;
    int waitCnt;
    cmxPkg::cntAdr_t a;
    sendReq(cmxPkg::OpCntRead, cmxPkg::rdLen_t'(len - 1), adr, '0, accCycle);
    waitCnt = 0;
    @(negedge clk_ni);
    while (ctlResp.valid !== 1'b1 && waitCnt < 10) begin
      @(negedge clk_ni);
      waitCnt++;
    end
    if (ctlResp.valid !== 1'b1) begin
      timeoutCnt++;
      $display("Timeout: no read response for address %0d", adr);
      return;
    end
    if (cycleCnt - accCycle != 2) begin
      errCnt++;
      $display("ERROR respLatency: got 0x%h expected 0x%h", cycleCnt - accCycle, 2);
    end
    for (int i = 0; i < len; i++) begin
      if (i > 0) begin
        @(negedge clk_ni);
      end
      a = adr + cmxPkg::cntAdr_t'(i);
      checkFlag("o_ctlResp.valid", ctlResp.valid, 1'b1);
      checkWord("o_ctlResp.rdata", ctlResp.rdata, model[a]);
    end
    @(negedge clk_ni);
    checkFlag("o_ctlResp.valid", ctlResp.valid, 1'b0);
  endtask

  task automatic doIncr(input cmxPkg::counterId_t id, input cmxPkg::word_t amount,
      output logic evt, output int accCycle);
    cmxPkg::cntAdr_t base;
    logic [31:0] newVal;
    base = {id, 3'd0};
    newVal = {model[base + 10'd1], model[base]} + 32'(amount);
    evt = (newVal == 32'd0) || (amount == 16'd0);
    sendReq(cmxPkg::OpCntIncr, 3'd0, base, amount, accCycle);
    for (int k = 1; k <= 4; k++) begin
      @(negedge clk_ni);
      checkFlag("o_ctlStall", ctlStall, 1'b1);
      checkFlag("o_intCnt", intCnt, (k == 4) ? evt : 1'b0);
      if (k == 4 && evt) begin
        checkId("o_intCntId", intCntId, id);
      end
    end
    model[base] = newVal[15:0];
    model[base + 10'd1] = newVal[31:16];
  endtask

  //////////////////////////////
  // Notification side
  task automatic collectNotes(input int expCount);
    int waitCnt;
    int tail;
    logic prevHeld;
    cmxPkg::word_t prevData;
    noteQ.delete();
    waitCnt = 0;
    tail = 0;
    prevHeld = 1'b0;
    prevData = '0;
    while (tail < 4 && waitCnt < 300) begin
      @(posedge clk_ni);
      mniStall <= randStall ? 1'($urandom % 2) : 1'b0;
      @(negedge clk_ni);
      waitCnt++;
      // Held word must not move
      if (prevHeld) begin
        checkFlag("o_mniWord.valid", mniWord.valid, 1'b1);
        checkWord("o_mniWord.data", mniWord.data, prevData);
      end
      if (mniWord.valid && !mniStall) begin
        noteQ.push_back(mniWord.data);
        lastNoteCycle = cycleCnt;
      end
      prevHeld = mniWord.valid && mniStall;
      prevData = mniWord.data;
      if (noteQ.size() >= expCount) begin
        tail++;
      end
    end
    if (tail < 4) begin
      timeoutCnt++;
      $display("Timeout: fewer than %0d notification words arrived", expCount);
    end
    @(posedge clk_ni);
    mniStall <= 1'b0;
  endtask

  task automatic compareNotes(input cmxPkg::counterId_t id, input logic evt, input logic err);
    cmxPkg::word_t expQ [$];
    cmxPkg::word_t dest;
    for (int d = 0; d < 2 && evt; d++) begin
      dest = model[{id, 3'(6 + d)}];
      if (dest[12]) begin
        expQ.push_back(dest & 16'h0FFF);
        expQ.push_back(model[{id, 3'(3 + 2 * d)}]);
        expQ.push_back(model[{id, 3'(2 + 2 * d)}]);
        expQ.push_back(err ? 16'h0000 : 16'h0001);
      end
    end
    if (noteQ.size() != expQ.size()) begin
      errCnt++;
      $display("ERROR noteCount: got 0x%h expected 0x%h", noteQ.size(), expQ.size());
    end else begin
      foreach (expQ[i]) begin
        checkWord("o_mniWord.data", noteQ[i], expQ[i]);
      end
    end
  endtask

  //////////////////////////////
  // Tests
  task automatic testBurstRw();
    for (int i = 0; i < 16; i++) begin
      writeWord(cmxPkg::cntAdr_t'(1016 + i), cmxPkg::word_t'($urandom));
    end
    // Length 5 and up cross address 1023
    for (int len = 1; len <= 8; len++) begin
      readBurst(cmxPkg::cntAdr_t'(1015 + len), len);
    end
  endtask

  task automatic testCarry();
    logic evt;
    int acc;
    setRecord(7'd6, {16'h1aaa, 16'h1bbb, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0012, 16'hfffa});
    doIncr(7'd6, cmxPkg::word_t'(16'h0006 + ($urandom % 200)), evt, acc);
    collectNotes(0);
    compareNotes(7'd6, evt, 1'b0);
    readBurst({7'd6, 3'd0}, 2);
  endtask

  task automatic testZeroCross();
    logic evt;
    int acc;
    setRecord(7'd5, {16'h3456, 16'hf123, 16'h4444, 16'h3333, 16'h2222, 16'h1111,
      16'hffff, 16'hfff0});
    doIncr(7'd5, 16'h0010, evt, acc);
    collectNotes(8);
    compareNotes(7'd5, evt, 1'b0);
    readBurst({7'd5, 3'd0}, 2);
  endtask

  task automatic testZeroAmount();
    logic evt;
    int acc;
    setRecord(7'd7, {16'h1abc, 16'h2123, 16'h7777, 16'h6666, 16'h5555, 16'h4444,
      16'h0000, 16'h0042});
    doIncr(7'd7, 16'h0000, evt, acc);
    collectNotes(4);
    compareNotes(7'd7, evt, 1'b1);
  endtask

  task automatic testBusyIncr();
    logic evt;
    logic evt2;
    int acc;
    int acc2;
    setRecord(7'd5, {16'h3456, 16'hf123, 16'h4444, 16'h3333, 16'h2222, 16'h1111,
      16'hffff, 16'hfff0});
    setRecord(7'd9, {16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0001, 16'h0000});
    doIncr(7'd5, 16'h0010, evt, acc);
    fork
      doIncr(7'd9, 16'h0100, evt2, acc2);
      collectNotes(8);
    join
    compareNotes(7'd5, evt, 1'b0);
    // Second increment goes in right after the notifier drains
    if (acc2 != lastNoteCycle + 1) begin
      errCnt++;
      $display("ERROR acceptCycle: got 0x%h expected 0x%h", acc2, lastNoteCycle + 1);
    end
    readBurst({7'd9, 3'd0}, 2);
  endtask

  initial begin
    seedVal = $urandom(9);
    ctlReq <= '0;
    mniStall <= 1'b0;
    rst_ni <= 1'b1;
    randStall = 1'b0;
    repeat (8) @(posedge clk_ni);
    rst_ni <= 1'b0;
    @(negedge clk_ni);
    checkFlag("o_ctlStall", ctlStall, 1'b0);
    checkFlag("o_ctlResp.valid", ctlResp.valid, 1'b0);
    checkFlag("o_intCnt", intCnt, 1'b0);
    checkFlag("o_mniWord.valid", mniWord.valid, 1'b0);
    testBurstRw();
    testCarry();
    testZeroCross();
    testZeroAmount();
    randStall = 1'b1;
    testZeroCross();
    randStall = 1'b0;
    testBusyIncr();
    $display("Summary: %0d check errors, %0d timeouts", errCnt, timeoutCnt);
    if (errCnt == 0 && timeoutCnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/cmxPkg.sv
src/cntMem.sv
src/cntIncrUnit.sv
src/ctlFsm.sv
src/mniNotifier.sv
src/cmxTop.sv
tests/cmxTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -sv
TOP = cmxTb
FILELIST = files.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
